//--- source/frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// ======================================================================
// fetch front end constants
// ======================================================================

// width of the fetch address and of the jump target
`define FE_W_ADDR 32

// fetch queue depth in 32-bit words, a power of two no smaller than 2
`define FE_FIFO_DEPTH 2

// first address fetched once reset is released
`define FE_RESET_VECTOR 32'h0000_0000

`endif

//--- source/frontend_pkg.sv
`default_nettype none

`include "frontend_consts.svh"

package frontend_pkg;

	// the two halfwords of a fetched word, hi sits at the higher address
	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} halves_s;

	// one bus word seen either whole or as two instruction parcels
	typedef union packed {
		logic [31:0] word;
		halves_s     halves;
	} fetch_word_u;

	// address phase request, size high means a 32-bit access
	typedef struct packed {
		logic [`FE_W_ADDR-1:0] addr;
		logic                  size;
	} mem_req_s;

	// redirect request from the processor
	typedef struct packed {
		logic [`FE_W_ADDR-1:0] target;
	} jump_s;

endpackage

`default_nettype wire

//--- source/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
	parameter int DEPTH = 2
) (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             push,
	input  wire                             pop,
	input  wire                             flush,
	input  wire frontend_pkg::fetch_word_u  wdata,
	output frontend_pkg::fetch_word_u       rdata,
	output logic                            empty,
	output logic                            full,
	output logic                            almost_full
);

	// pointers carry one extra wrap bit so that full and empty differ
	localparam int W_PTR = $clog2(DEPTH) + 1;

	frontend_pkg::fetch_word_u mem [DEPTH];
	logic [W_PTR-1:0] wptr;
	logic [W_PTR-1:0] rptr;
	logic [W_PTR-1:0] level;

	assign level       = wptr - rptr;
	assign empty       = wptr == rptr;
	// full when only the wrap bits differ
	assign full        = (wptr ^ rptr) == {1'b1, {(W_PTR-1){1'b0}}};
	assign almost_full = level == W_PTR'(DEPTH - 1);

	// head of queue falls through without a read strobe
	assign rdata = mem[rptr[W_PTR-2:0]];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wptr[W_PTR-2:0]] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + W_PTR'(1);
			end
			// a flush drops everything, including a word written this very cycle
			if (flush) begin
				rptr <= wptr + {{(W_PTR-1){1'b0}}, push};
			end else if (pop) begin
				rptr <= rptr + W_PTR'(1);
			end
		end
	end

	// the request side must keep within the queue space
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
		else $error("fetch queue pushed while full");
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
		else $error("fetch queue popped while empty");

endmodule

`default_nettype wire

//--- source/fetch_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tracker (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        addr_issued,
	input  wire        data_vld,
	input  wire        flush,
	output logic [1:0] pending,
	output logic       flushing
);

	// number of in-flight words that belong to a discarded fetch stream
	logic [1:0] discard;

	assign flushing = |discard;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 2'd0;
			discard <= 2'd0;
		end else begin
			// one more for each accepted address, one less for each returned word
			pending <= pending + {1'b0, addr_issued} - {1'b0, data_vld};
			// on a flush everything still in flight is stale
			// a word returning in the flush cycle is already accounted for
			if (flush) begin
				discard <= pending - {1'b0, data_vld};
			end else if (flushing && data_vld) begin
				discard <= discard - 2'd1;
			end
		end
	end

	// ======================================================================
	// checks on the bus traffic
	// ======================================================================

	// the request side holds off at two outstanding fetches
	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n) pending != 2'd3)
		else $error("more than two fetches outstanding");

	// only words that are actually in flight can be dropped
	a_discard_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		discard <= pending)
		else $error("discard count above pending count");

	// bus returns data only for accepted addresses
	a_no_spurious_data: assert property (@(posedge clk) disable iff (!rst_n)
		!(data_vld && pending == 2'd0))
		else $error("data returned with no fetch outstanding");

endmodule

`default_nettype wire

//--- source/fetch_request_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module fetch_request_fsm (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       mem_addr_rdy,
	input  wire frontend_pkg::jump_s  jump,
	input  wire                       jump_vld,
	input  wire [1:0]                 pending,
	input  wire                       q_full,
	input  wire                       q_almost_full,
	output frontend_pkg::mem_req_s    mem_req,
	output logic                      mem_addr_vld,
	output logic                      addr_issued,
	output logic                      jump_rdy,
	output logic                      jump_taken
);

	localparam int W_ADDR = `FE_W_ADDR;

	typedef enum logic [1:0] {
		SEQUENTIAL,
		HOLD,
		STALL
	} state_e;

	state_e state_q;
	state_e state_d;
	// word address of the next sequential fetch, runs ahead of the PC
	logic [W_ADDR-1:0] fetch_addr;
	// the held request is the 16-bit access of an unaligned jump
	logic unaligned_hold;
	logic jump_unaligned;
	logic fetch_stall;

	// a held address phase may not be replaced, so jumps wait
	assign jump_rdy       = state_q != HOLD;
	assign jump_taken     = jump_vld && jump_rdy;
	assign jump_unaligned = jump_taken && jump.target[1];
	assign addr_issued    = mem_addr_vld && mem_addr_rdy;

	// registered pending keeps the bus ready off the address phase path
	assign fetch_stall = q_full || (q_almost_full && |pending) || pending > 2'd1;

	// ======================================================================
	// address phase request
	// ======================================================================
	always_comb begin
		mem_req.addr = fetch_addr;
		mem_req.size = 1'b1;
		mem_addr_vld = 1'b1;
		case (state_q)
			HOLD: begin
				// repeat exactly what the bus has not yet taken
				mem_req.addr = {fetch_addr[W_ADDR-1:2], unaligned_hold, 1'b0};
				mem_req.size = !unaligned_hold;
			end
			SEQUENTIAL, STALL: begin
				// a jump goes out at once, even while stalled
				if (jump_vld) begin
					mem_req.addr = jump.target;
					mem_req.size = !jump_unaligned;
				end else if (fetch_stall) begin
					mem_addr_vld = 1'b0;
				end
			end
			default: begin
				mem_addr_vld = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (mem_addr_vld && !mem_addr_rdy) begin
			state_d = HOLD;
		end else if (!mem_addr_vld) begin
			state_d = STALL;
		end else begin
			state_d = SEQUENTIAL;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q        <= SEQUENTIAL;
			fetch_addr     <= `FE_RESET_VECTOR;
			unaligned_hold <= 1'b0;
		end else begin
			state_q <= state_d;
			if (jump_taken) begin
				// skip past the target word when its own request goes through now
				fetch_addr <= {jump.target[W_ADDR-1:2]
					+ {{(W_ADDR-3){1'b0}}, mem_addr_rdy}, 2'b00};
			end else if (addr_issued) begin
				fetch_addr <= fetch_addr + W_ADDR'(4);
			end
			if (mem_addr_rdy) begin
				unaligned_hold <= 1'b0;
			end
			if (jump_unaligned) begin
				unaligned_hold <= !mem_addr_rdy;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/instr_assembly.sv
`timescale 1ns/1ps
`default_nettype none

module instr_assembly (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire frontend_pkg::fetch_word_u  fetch_word,
	input  wire                             fetch_vld,
	input  wire                             jump_taken,
	input  wire                             jump_unaligned,
	input  wire                             flushing,
	input  wire [1:0]                       cir_use,
	output frontend_pkg::fetch_word_u       cir,
	output logic [1:0]                      cir_vld,
	output logic                            refill
);

	// halfwords held across cir and the spill register, 0 to 3
	logic [1:0] buf_level;
	logic [1:0] buf_level_next;
	logic [1:0] level_no_fetch;
	// third halfword, sits above cir
	logic [15:0] spill;
	// first word after an unaligned jump only carries its high halfword
	logic unaligned_pending;
	logic [47:0] shifted;
	logic [47:0] assembled;

	// ======================================================================
	// shift and refill
	// ======================================================================

	// move the leftovers down by what decode took this cycle
	// slots that end up invalid or overwritten get whatever is cheapest
	always_comb begin
		case (cir_use)
			2'd2:    shifted = {spill, cir.halves.hi, spill};
			2'd1:    shifted = {spill, spill, cir.halves.hi};
			default: shifted = {spill, cir.word};
		endcase
	end

	assign level_no_fetch = buf_level - cir_use;

	// ask for a new word whenever fewer than two halfwords would remain
	assign refill = !level_no_fetch[1];

	// overlay the fetch word just above the surviving halfwords
	always_comb begin
		if (unaligned_pending) begin
			assembled = {shifted[47:16], fetch_word.halves.hi};
		end else if (level_no_fetch[1]) begin
			assembled = shifted;
		end else if (level_no_fetch[0]) begin
			assembled = {fetch_word.word, shifted[15:0]};
		end else begin
			assembled = {shifted[47:32], fetch_word.word};
		end
	end

	// a redirect or stale data in flight empties the buffer
	always_comb begin
		if (jump_taken || flushing) begin
			buf_level_next = 2'd0;
		end else if (fetch_vld && unaligned_pending) begin
			buf_level_next = 2'd1;
		end else begin
			buf_level_next = buf_level + {refill && fetch_vld, 1'b0} - cir_use;
		end
	end

	// ======================================================================
	// state
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level         <= 2'd0;
			cir_vld           <= 2'd0;
			unaligned_pending <= 1'b0;
		end else begin
			buf_level <= buf_level_next;
			// cir shows at most two halfwords, a third waits in spill
			cir_vld   <= buf_level_next & ~(buf_level_next >> 1);
			if (fetch_vld && !flushing) begin
				unaligned_pending <= 1'b0;
			end
			if (jump_taken) begin
				unaligned_pending <= jump_unaligned;
			end
		end
	end

	always_ff @(posedge clk) begin
		cir.word <= assembled[31:0];
		spill    <= assembled[47:32];
	end

	// decode can only take halfwords it has been given
	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld)
		else $error("decode consumed more halfwords than valid in cir");

endmodule

`default_nettype wire

//--- source/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module fetch_frontend (
	input  wire                             clk,
	input  wire                             rst_n,
	output frontend_pkg::mem_req_s          mem_req,
	output logic                            mem_addr_vld,
	input  wire                             mem_addr_rdy,
	input  wire frontend_pkg::fetch_word_u  mem_data,
	input  wire                             mem_data_vld,
	input  wire frontend_pkg::jump_s        jump,
	input  wire                             jump_vld,
	output logic                            jump_rdy,
	output frontend_pkg::fetch_word_u       cir,
	output logic [1:0]                      cir_vld,
	input  wire [1:0]                       cir_use
);

	frontend_pkg::fetch_word_u q_rdata;
	frontend_pkg::fetch_word_u fetch_word;
	logic       q_push;
	logic       q_pop;
	logic       q_empty;
	logic       q_full;
	logic       q_almost_full;
	logic [1:0] pending;
	logic       flushing;
	logic       addr_issued;
	logic       jump_taken;
	logic       refill;
	logic       fetch_vld;

	// an empty queue lets bus data straight through to the assembly yard
	assign fetch_word = q_empty ? mem_data : q_rdata;
	assign fetch_vld  = !q_empty || (mem_data_vld && !flushing);
	// stale words are dropped and forwarded words are not stored twice
	assign q_push     = mem_data_vld && !flushing && !(refill && q_empty);
	assign q_pop      = refill && !q_empty;

	fetch_queue #(
		.DEPTH (`FE_FIFO_DEPTH)
	) fetch_queue_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (q_push),
		.pop         (q_pop),
		.flush       (jump_taken),
		.wdata       (mem_data),
		.rdata       (q_rdata),
		.empty       (q_empty),
		.full        (q_full),
		.almost_full (q_almost_full)
	);

	fetch_tracker fetch_tracker_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.addr_issued (addr_issued),
		.data_vld    (mem_data_vld),
		.flush       (jump_taken),
		.pending     (pending),
		.flushing    (flushing)
	);

	fetch_request_fsm fetch_request_fsm_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_addr_rdy  (mem_addr_rdy),
		.jump          (jump),
		.jump_vld      (jump_vld),
		.pending       (pending),
		.q_full        (q_full),
		.q_almost_full (q_almost_full),
		.mem_req       (mem_req),
		.mem_addr_vld  (mem_addr_vld),
		.addr_issued   (addr_issued),
		.jump_rdy      (jump_rdy),
		.jump_taken    (jump_taken)
	);

	instr_assembly instr_assembly_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.fetch_word     (fetch_word),
		.fetch_vld      (fetch_vld),
		.jump_taken     (jump_taken),
		.jump_unaligned (jump.target[1]),
		.flushing       (flushing),
		.cir_use        (cir_use),
		.cir            (cir),
		.cir_vld        (cir_vld),
		.refill         (refill)
	);

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	// free running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- verif/fetch_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module fetch_frontend_tb;

	// the tests need about 2500 cycles and the limit leaves more than twice that
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int JUMP_ALIGNED   = 0;
	localparam int JUMP_UNALIGNED = 1;
	localparam int JUMP_MIXED     = 2;

	logic                      clk;
	logic                      rst_n;
	frontend_pkg::mem_req_s    mem_req;
	logic                      mem_addr_vld;
	logic                      mem_addr_rdy;
	frontend_pkg::fetch_word_u mem_data;
	logic                      mem_data_vld;
	frontend_pkg::jump_s       jump;
	logic                      jump_vld;
	logic                      jump_rdy;
	frontend_pkg::fetch_word_u cir;
	logic [1:0]                cir_vld;
	logic [1:0]                cir_use;

	integer seed = 35395;
	int cycle;
	int watchdog;
	int tests;
	int checks;
	int errors;
	int consumed;
	int jumps;
	// word addresses in flight on the bus and the cycle each one returns
	logic [31:0] bus_addr_q [$];
	int bus_due_q [$];
	int last_due;
	int outstanding;
	// reference PC of the next instruction decode should see
	logic [31:0] pc;
	logic held;
	frontend_pkg::mem_req_s held_req;
	logic jump_seen;

	tb_clock #(.PERIOD(100)) tb_clock_i (.clk(clk));

	fetch_frontend fetch_frontend_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_req      (mem_req),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.mem_data     (mem_data),
		.mem_data_vld (mem_data_vld),
		.jump         (jump),
		.jump_vld     (jump_vld),
		.jump_rdy     (jump_rdy),
		.cir          (cir),
		.cir_vld      (cir_vld),
		.cir_use      (cir_use)
	);

	// ======================================================================
	// memory contents and random helpers
	// ======================================================================

	// memory content is a hash of the halfword address
	function automatic logic [15:0] halfword_at(input logic [31:0] addr);
		logic [31:0] x;
		logic [15:0] h;
		x = addr * 32'h9e37_79b1;
		x = x ^ (x >> 15);
		h = x[15:0];
		// one mix bit picks a 32-bit opcode for about half of all parcels
		if (x[16]) begin
			h[1:0] = 2'b11;
		end else if (h[1:0] == 2'b11) begin
			h[1:0] = 2'b01;
		end
		return h;
	endfunction

	function automatic bit chance(input int pct);
		int r;
		r = $random(seed);
		return ((r & 32'h7fff_ffff) % 100) < pct;
	endfunction

	function automatic logic [31:0] pick_target(input int mode);
		logic [31:0] t;
		t = $random(seed) & 32'h0000_3ffc;
		if (mode == JUMP_UNALIGNED || (mode == JUMP_MIXED && chance(50))) begin
			t[1] = 1'b1;
		end
		return t;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	// ======================================================================
	// one clock cycle of bus, processor and decode
	// ======================================================================
	task automatic run_cycle(input int rdy_pct, input int stall_pct, input int jump_pct,
		input int jump_mode);
		logic [31:0] waddr;
		logic ret;
		logic accept;
		int due;
		@(negedge clk);
		cycle++;
		// a taken jump empties the instruction register one cycle later
		if (jump_seen) begin
			check_value("cir_vld after jump", 32'(cir_vld), 32'd0);
			jump_vld  = 1'b0;
			jump_seen = 1'b0;
		end
		// jumps are raised only where the bus cannot end up with three fetches
		if (jump_vld && !jump_rdy) begin
			jump.target = pick_target(jump_mode);
		end else if (!jump_vld && chance(jump_pct)
			&& (outstanding == 0 || (jump_rdy && outstanding < 2))) begin
			jump_vld    = 1'b1;
			jump.target = pick_target(jump_mode);
		end
		// data phase returns the oldest accepted word once it is due
		ret           = 1'b0;
		mem_data.word = $random(seed);
		if (bus_due_q.size() > 0 && bus_due_q[0] <= cycle) begin
			waddr              = bus_addr_q.pop_front();
			void'(bus_due_q.pop_front());
			ret                = 1'b1;
			mem_data.halves.lo = halfword_at(waddr);
			mem_data.halves.hi = halfword_at(waddr + 32'd2);
		end
		mem_data_vld = ret;
		mem_addr_rdy = chance(rdy_pct);
		// decode takes one parcel for a 16-bit opcode, two for a 32-bit one
		cir_use = 2'd0;
		if (cir_vld != 2'd0 && !chance(stall_pct)) begin
			if (cir.halves.lo[1:0] != 2'b11) begin
				cir_use = 2'd1;
			end else if (cir_vld == 2'd2) begin
				cir_use = 2'd2;
			end
		end
		if (cir_use != 2'd0) begin
			check_value("cir.lo", 32'(cir.halves.lo), 32'(halfword_at(pc)));
			if (cir_use == 2'd2) begin
				check_value("cir.hi", 32'(cir.halves.hi), 32'(halfword_at(pc + 32'd2)));
			end
			pc = pc + {29'd0, cir_use, 1'b0};
			consumed++;
		end
		// let the combinational address phase settle before sampling it
		#1;
		if (held) begin
			check_value("mem_addr_vld held", 32'(mem_addr_vld), 32'd1);
			check_value("mem_req.addr held", mem_req.addr, held_req.addr);
			check_value("mem_req.size held", 32'(mem_req.size), 32'(held_req.size));
			check_value("jump_rdy held", 32'(jump_rdy), 32'd0);
		end else if (mem_addr_vld && !(jump_vld && jump_rdy)) begin
			// a plain sequential fetch always reads a whole word
			check_value("mem_req.size", 32'(mem_req.size), 32'd1);
		end
		held     = mem_addr_vld && !mem_addr_rdy;
		held_req = mem_req;
		if (jump_vld && jump_rdy) begin
			check_value("mem_addr_vld jump", 32'(mem_addr_vld), 32'd1);
			check_value("mem_req.addr jump", mem_req.addr, jump.target);
			// only an unaligned target is fetched as a single halfword
			check_value("mem_req.size jump", 32'(mem_req.size), 32'(!jump.target[1]));
			pc        = jump.target;
			jump_seen = 1'b1;
			jumps++;
		end
		accept = mem_addr_vld && mem_addr_rdy;
		if (accept) begin
			due = cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 3);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			bus_addr_q.push_back({mem_req.addr[31:2], 2'b00});
			bus_due_q.push_back(due);
		end
		outstanding = outstanding + int'(accept) - int'(ret);
		if (outstanding > 2) begin
			report_problem("more than two accepted fetch addresses without returned data");
		end
	endtask

	task automatic run_test(input string name, input int n_instr, input int rdy_pct,
		input int stall_pct, input int jump_pct, input int jump_mode);
		int err0;
		int start;
		int jumps0;
		err0   = errors;
		start  = consumed;
		jumps0 = jumps;
		while (consumed - start < n_instr) begin
			run_cycle(rdy_pct, stall_pct, jump_pct, jump_mode);
		end
		tests++;
		$display("test %0d %s: %0d instructions, %0d jumps, %0d errors", tests, name,
			consumed - start, jumps - jumps0, errors - err0);
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		rst_n        = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_data     = '0;
		mem_data_vld = 1'b0;
		jump         = '0;
		jump_vld     = 1'b0;
		cir_use      = 2'd0;
		pc           = `FE_RESET_VECTOR;
		held         = 1'b0;
		jump_seen    = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		#1;
		// out of reset the first fetch is already on the bus
		check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd1);
		check_value("mem_req.addr", mem_req.addr, `FE_RESET_VECTOR);
		check_value("jump_rdy", 32'(jump_rdy), 32'd1);
		check_value("cir_vld", 32'(cir_vld), 32'd0);
		held     = mem_addr_vld && !mem_addr_rdy;
		held_req = mem_req;
		run_test("reset vector", 20, 100, 0, 0, JUMP_ALIGNED);
		run_test("sequential mix", 200, 100, 0, 0, JUMP_ALIGNED);
		run_test("aligned jumps", 200, 100, 10, 8, JUMP_ALIGNED);
		run_test("unaligned jumps", 200, 100, 10, 8, JUMP_UNALIGNED);
		run_test("wait states and stalls", 400, 50, 30, 4, JUMP_MIXED);
		run_test("held requests and jumps", 150, 25, 20, 10, JUMP_MIXED);
		$display("%0d tests, %0d checks, %0d errors, %0d instructions, %0d jumps",
			tests, checks, errors, consumed, jumps);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		watchdog = 0;
		while (watchdog < TIMEOUT_CYCLES) begin
			@(posedge clk);
			watchdog++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/frontend_pkg.sv
source/fetch_queue.sv
source/fetch_tracker.sv
source/fetch_request_fsm.sv
source/instr_assembly.sv
source/fetch_frontend.sv
verif/tb_clock.sv
verif/fetch_frontend_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_frontend_tb \
	-f list.f -o fetch_frontend_sim && ./obj_dir/fetch_frontend_sim | tee sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
